/* Makefile */
VERILATOR   ?= verilator
TOP         ?= tb_rv_exec
FILELIST    ?= rv_exec.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
ERROR_LIMIT ?= 100
VFLAGS      ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then \
		echo "Simulation reported failures, see $(LOG)"; exit 1; \
	elif ! grep -q "All tests passed" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* alu.sv */
`timescale 1ns/10ps

module alu (
    input logic clk_i,
    input logic arst_n_i,
    alu_if.alu  bus
);

    logic [rv_exec_pkg::XLEN-1:0] sh_q;
    logic [rv_exec_pkg::XLEN-1:0] res;
    logic [rv_exec_pkg::XLEN-1:0] a;
    logic [rv_exec_pkg::XLEN-1:0] b;

    assign a = bus.operand_a;
    assign b = bus.operand_b;

    // Serial shifter, one bit per step
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sh_q <= '0;
        end else if (bus.shift_load) begin
            sh_q <= a;
        end else if (bus.shift_step) begin
            case (bus.alu_ctrl)
                rv_exec_pkg::ALU_SLL: sh_q <= {sh_q[rv_exec_pkg::XLEN-2:0], 1'b0};
                rv_exec_pkg::ALU_SRL: sh_q <= {1'b0, sh_q[rv_exec_pkg::XLEN-1:1]};
                rv_exec_pkg::ALU_SRA: sh_q <= {sh_q[rv_exec_pkg::XLEN-1],
                                               sh_q[rv_exec_pkg::XLEN-1:1]};
                default:              sh_q <= sh_q;
            endcase
        end
    end

    always_comb begin
        case (bus.alu_ctrl)
            rv_exec_pkg::ALU_ADD:  res = a + b;
            rv_exec_pkg::ALU_SUB:  res = a - b;
            rv_exec_pkg::ALU_SLT:  res = {31'b0, $signed(a) < $signed(b)};
            rv_exec_pkg::ALU_SLTU: res = {31'b0, a < b};
            rv_exec_pkg::ALU_OR:   res = a | b;
            rv_exec_pkg::ALU_XOR:  res = a ^ b;
            rv_exec_pkg::ALU_AND:  res = a & b;
            rv_exec_pkg::ALU_SLL,
            rv_exec_pkg::ALU_SRL,
            rv_exec_pkg::ALU_SRA:  res = sh_q;  // Shift register view
            default:               res = '0;    // ALU_ZERO
        endcase
    end

    assign bus.result = res;
    assign bus.zero   = (res == '0);

endmodule

/* alu_decoder.sv */
`timescale 1ns/10ps

module alu_decoder (
    input  rv_exec_pkg::alu_op_e   alu_op_i,
    input  logic [2:0]             funct3_i,
    input  logic [6:0]             funct7_i,
    output rv_exec_pkg::alu_ctrl_e alu_control_o,
    output logic                   illegal_o
);

    // Shared by R-type and the immediate shifts
    logic f7_zero;
    logic f7_alt;

    assign f7_zero = (funct7_i == 7'h00);
    assign f7_alt  = (funct7_i == 7'h20);

    always_comb begin
        alu_control_o = rv_exec_pkg::ALU_ADD;
        illegal_o     = 1'b0;
        case (alu_op_i)
            rv_exec_pkg::ALU_OP_ITYPE: begin
                case (funct3_i)
                    3'h0: alu_control_o = rv_exec_pkg::ALU_ADD;   // ADDI
                    3'h2: alu_control_o = rv_exec_pkg::ALU_SLT;   // SLTI
                    3'h3: alu_control_o = rv_exec_pkg::ALU_SLTU;  // SLTIU
                    3'h4: alu_control_o = rv_exec_pkg::ALU_XOR;   // XORI
                    3'h6: alu_control_o = rv_exec_pkg::ALU_OR;    // ORI
                    3'h7: alu_control_o = rv_exec_pkg::ALU_AND;   // ANDI
                    3'h1: begin
                        alu_control_o = rv_exec_pkg::ALU_SLL;     // SLLI
                        illegal_o     = !f7_zero;
                    end
                    default: begin
                        // SRLI or SRAI, picked by funct7
                        alu_control_o = f7_alt ? rv_exec_pkg::ALU_SRA : rv_exec_pkg::ALU_SRL;
                        illegal_o     = !(f7_zero || f7_alt);
                    end
                endcase
            end
            rv_exec_pkg::ALU_OP_BRANCH: begin
                alu_control_o = rv_exec_pkg::ALU_SUB;  // Compare through zero flag
            end
            rv_exec_pkg::ALU_OP_RTYPE: begin
                illegal_o = !f7_zero;
                case (funct3_i)
                    3'h0: begin
                        alu_control_o = f7_alt ? rv_exec_pkg::ALU_SUB : rv_exec_pkg::ALU_ADD;
                        illegal_o     = !(f7_zero || f7_alt);
                    end
                    3'h1: alu_control_o = rv_exec_pkg::ALU_SLL;
                    3'h2: alu_control_o = rv_exec_pkg::ALU_SLT;
                    3'h3: alu_control_o = rv_exec_pkg::ALU_SLTU;
                    3'h4: alu_control_o = rv_exec_pkg::ALU_XOR;
                    3'h5: begin
                        alu_control_o = f7_alt ? rv_exec_pkg::ALU_SRA : rv_exec_pkg::ALU_SRL;
                        illegal_o     = !(f7_zero || f7_alt);
                    end
                    3'h6: alu_control_o = rv_exec_pkg::ALU_OR;
                    default: alu_control_o = rv_exec_pkg::ALU_AND;
                endcase
            end
            default: begin
                alu_control_o = rv_exec_pkg::ALU_ADD;  // Store address
            end
        endcase
        if (illegal_o) begin
            alu_control_o = rv_exec_pkg::ALU_ZERO;  // Keeps the shifter idle
        end
    end

endmodule

/* alu_if.sv */
`timescale 1ns/10ps

interface alu_if;

    logic [rv_exec_pkg::XLEN-1:0] operand_a;
    logic [rv_exec_pkg::XLEN-1:0] operand_b;
    rv_exec_pkg::alu_ctrl_e       alu_ctrl;
    logic                         shift_load;  // Load shift register from operand_a
    logic                         shift_step;  // One bit per cycle
    logic [rv_exec_pkg::XLEN-1:0] result;
    logic                         zero;

    modport ctrl (
        output operand_a, operand_b, alu_ctrl, shift_load, shift_step,
        input  result, zero
    );

    modport alu (
        input  operand_a, operand_b, alu_ctrl, shift_load, shift_step,
        output result, zero
    );

endinterface

/* exec_fsm.sv */
`timescale 1ns/10ps

module exec_fsm (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    input  logic                               instr_valid_i,
    input  logic [31:0]                        instr_i,
    output logic                               ready_o,
    input  rv_exec_pkg::decode_t               dec_i,
    input  logic                               alu_illegal_i,
    input  rv_exec_pkg::alu_ctrl_e             alu_ctrl_i,
    input  logic [rv_exec_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [rv_exec_pkg::XLEN-1:0]       rs2_data_i,
    alu_if.ctrl                                bus,
    output logic                               cnt_load_o,
    output logic                               cnt_step_o,
    input  logic                               cnt_last_i,
    output logic                               rf_we_o,
    output logic [rv_exec_pkg::XLEN-1:0]       rf_wd_o,
    output logic                               wb_valid_o,
    output logic [rv_exec_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [rv_exec_pkg::XLEN-1:0]       wb_data_o,
    output logic                               br_valid_o,
    output logic                               br_taken_o,
    output logic                               st_valid_o,
    output logic [rv_exec_pkg::XLEN-1:0]       st_addr_o,
    output logic [rv_exec_pkg::XLEN-1:0]       st_data_o,
    output logic                               illegal_o,
    output logic [31:0]                        instr_q_o
);

    rv_exec_pkg::fsm_state_e      state_q;
    rv_exec_pkg::fsm_state_e      state_d;
    logic [31:0]                  instr_q;
    logic                         illegal_q;
    logic [rv_exec_pkg::XLEN-1:0] result_q;
    logic                         zero_q;
    logic                         is_shift;
    logic                         shamt_nz;
    logic                         in_wb;

    assign is_shift = (alu_ctrl_i == rv_exec_pkg::ALU_SLL) ||
                      (alu_ctrl_i == rv_exec_pkg::ALU_SRL) ||
                      (alu_ctrl_i == rv_exec_pkg::ALU_SRA);
    assign shamt_nz = (bus.operand_b[rv_exec_pkg::SHAMT_W-1:0] != '0);

    always_comb begin
        state_d = state_q;
        case (state_q)
            rv_exec_pkg::ST_IDLE:   if (instr_valid_i) state_d = rv_exec_pkg::ST_DECODE;
            rv_exec_pkg::ST_DECODE: state_d = rv_exec_pkg::ST_EXEC;
            rv_exec_pkg::ST_EXEC:   state_d = (is_shift && shamt_nz) ? rv_exec_pkg::ST_SHIFT
                                                                     : rv_exec_pkg::ST_WB;
            rv_exec_pkg::ST_SHIFT:  if (cnt_last_i) state_d = rv_exec_pkg::ST_WB;
            default:                state_d = rv_exec_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= rv_exec_pkg::ST_IDLE;
            illegal_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == rv_exec_pkg::ST_DECODE) begin
                illegal_q <= dec_i.illegal_op || alu_illegal_i;
            end
        end
    end

    // Instruction and result hold registers
    always_ff @(posedge clk_i) begin
        if ((state_q == rv_exec_pkg::ST_IDLE) && instr_valid_i) begin
            instr_q <= instr_i;
        end
        if ((state_q == rv_exec_pkg::ST_EXEC) || (state_q == rv_exec_pkg::ST_SHIFT)) begin
            result_q <= bus.result;  // Last sample is the final value
            zero_q   <= bus.zero;
        end
    end

    assign ready_o   = (state_q == rv_exec_pkg::ST_IDLE);
    assign instr_q_o = instr_q;

    assign bus.operand_a  = rs1_data_i;
    assign bus.operand_b  = ((dec_i.kind == rv_exec_pkg::KIND_IMM) ||
                             (dec_i.kind == rv_exec_pkg::KIND_STORE)) ? dec_i.imm : rs2_data_i;
    assign bus.alu_ctrl   = alu_ctrl_i;
    assign bus.shift_load = (state_q == rv_exec_pkg::ST_DECODE);
    // First step in EXEC, so the last SHIFT cycle already holds the result
    assign bus.shift_step = ((state_q == rv_exec_pkg::ST_EXEC) && is_shift && shamt_nz) ||
                            ((state_q == rv_exec_pkg::ST_SHIFT) && !cnt_last_i);

    assign cnt_load_o = (state_q == rv_exec_pkg::ST_EXEC);
    assign cnt_step_o = (state_q == rv_exec_pkg::ST_SHIFT);

    assign in_wb      = (state_q == rv_exec_pkg::ST_WB);
    assign illegal_o  = in_wb && illegal_q;
    assign wb_valid_o = in_wb && !illegal_q && ((dec_i.kind == rv_exec_pkg::KIND_REG) ||
                                                (dec_i.kind == rv_exec_pkg::KIND_IMM));
    assign br_valid_o = in_wb && !illegal_q && (dec_i.kind == rv_exec_pkg::KIND_BRANCH);
    assign st_valid_o = in_wb && !illegal_q && (dec_i.kind == rv_exec_pkg::KIND_STORE);

    assign wb_rd_o    = instr_q[11:7];
    assign wb_data_o  = (wb_rd_o == '0) ? '0 : result_q;  // x0 reports zero
    assign br_taken_o = instr_q[12] ? !zero_q : zero_q;   // Inverted for BNE
    assign st_addr_o  = result_q;
    assign st_data_o  = rs2_data_i;

    assign rf_we_o = wb_valid_o;
    assign rf_wd_o = result_q;

endmodule

/* main_decoder.sv */
`timescale 1ns/10ps

module main_decoder (
    input  logic [31:0]          instr_i,
    output rv_exec_pkg::decode_t dec_o
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};

    always_comb begin
        dec_o.kind       = rv_exec_pkg::KIND_REG;
        dec_o.alu_op     = rv_exec_pkg::ALU_OP_ITYPE;
        dec_o.imm        = '0;
        dec_o.illegal_op = 1'b0;
        case (opcode)
            rv_exec_pkg::OPC_RTYPE: begin
                dec_o.alu_op = rv_exec_pkg::ALU_OP_RTYPE;
            end
            rv_exec_pkg::OPC_ITYPE: begin
                dec_o.kind = rv_exec_pkg::KIND_IMM;
                dec_o.imm  = imm_i;
            end
            rv_exec_pkg::OPC_BRANCH: begin
                dec_o.kind       = rv_exec_pkg::KIND_BRANCH;
                dec_o.alu_op     = rv_exec_pkg::ALU_OP_BRANCH;
                dec_o.imm        = imm_b;
                dec_o.illegal_op = (funct3 != 3'b000) && (funct3 != 3'b001);  // BEQ, BNE only
            end
            rv_exec_pkg::OPC_STORE: begin
                dec_o.kind       = rv_exec_pkg::KIND_STORE;
                dec_o.alu_op     = rv_exec_pkg::ALU_OP_STORE;
                dec_o.imm        = imm_s;
                dec_o.illegal_op = (funct3 != 3'b010);  // SW only
            end
            default: begin
                dec_o.illegal_op = 1'b1;  // Unsupported opcode
            end
        endcase
    end

endmodule

/* register_file.sv */
`timescale 1ns/10ps

module register_file (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    input  logic [rv_exec_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [rv_exec_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [rv_exec_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv_exec_pkg::XLEN-1:0]       rs2_data_o,
    input  logic                               we_i,
    input  logic [rv_exec_pkg::REG_ADDR_W-1:0] rd_addr_i,
    input  logic [rv_exec_pkg::XLEN-1:0]       rd_data_i
);

    logic [rv_exec_pkg::XLEN-1:0] regs_q [32];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (rd_addr_i != '0)) begin
            regs_q[rd_addr_i] <= rd_data_i;
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];  // x0 reads zero
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

/* rv_exec.f */
rv_exec_pkg.sv
alu_if.sv
main_decoder.sv
alu_decoder.sv
alu.sv
shift_counter.sv
register_file.sv
exec_fsm.sv
rv_exec_top.sv
rv_exec_chk.sv
tb_rv_exec.sv

/* rv_exec_chk.sv */
`timescale 1ns/10ps

module rv_exec_chk (
    input logic clk_i,
    input logic arst_n_i,
    input logic instr_valid_i,
    input logic ready_i,
    input logic wb_valid_i,
    input logic br_valid_i,
    input logic st_valid_i,
    input logic illegal_i,
    input logic shift_step_i
);

    int unsigned fail_count = 0;  // Failed assertions so far
    logic        accept;
    logic        outcome;
    logic        busy_q;

    assign accept  = ready_i && instr_valid_i;
    assign outcome = wb_valid_i || br_valid_i || st_valid_i || illegal_i;

    // Instruction in flight from accept to outcome
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= 1'b0;
        end else if (accept) begin
            busy_q <= 1'b1;
        end else if (outcome) begin
            busy_q <= 1'b0;
        end
    end

    one_outcome: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $onehot0({wb_valid_i, br_valid_i, st_valid_i, illegal_i}))
    else begin
        fail_count++;
        $error("More than one outcome pulse high");
    end

    busy_not_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        busy_q |-> !ready_i)
    else begin
        fail_count++;
        $error("ready_o high while an instruction is in flight");
    end

    // No shift step in EXEC means no ST_SHIFT
    fixed_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ($past(accept, 3) && !$past(shift_step_i, 1)) |-> outcome)
    else begin
        fail_count++;
        $error("Non-shift outcome not 3 cycles after accept");
    end

endmodule

bind rv_exec_top rv_exec_chk u_chk (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .ready_i       (ready_o),
    .wb_valid_i    (wb_valid_o),
    .br_valid_i    (br_valid_o),
    .st_valid_i    (st_valid_o),
    .illegal_i     (illegal_o),
    .shift_step_i  (alu_bus.shift_step)
);

/* rv_exec_pkg.sv */
package rv_exec_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;

    localparam logic [6:0] OPC_RTYPE  = 7'b0110011;
    localparam logic [6:0] OPC_ITYPE  = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // Operation class from the main decoder
    typedef enum logic [1:0] {
        ALU_OP_ITYPE  = 2'b00,
        ALU_OP_BRANCH = 2'b01,
        ALU_OP_RTYPE  = 2'b10,
        ALU_OP_STORE  = 2'b11
    } alu_op_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_SLL  = 4'h2,
        ALU_SLT  = 4'h3,
        ALU_SLTU = 4'h4,
        ALU_SRL  = 4'h5,
        ALU_SRA  = 4'h6,
        ALU_OR   = 4'h7,
        ALU_XOR  = 4'h8,
        ALU_AND  = 4'h9,
        ALU_ZERO = 4'hA
    } alu_ctrl_e;

    typedef enum logic [1:0] {
        KIND_REG,
        KIND_IMM,
        KIND_BRANCH,
        KIND_STORE
    } instr_kind_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_DECODE,
        ST_EXEC,
        ST_SHIFT,
        ST_WB
    } fsm_state_e;

    typedef struct packed {
        instr_kind_e     kind;
        alu_op_e         alu_op;
        logic [XLEN-1:0] imm;         // Sign extended, format by kind
        logic            illegal_op;  // Opcode or variant not supported
    } decode_t;

endpackage

/* rv_exec_top.sv */
`timescale 1ns/10ps

module rv_exec_top (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    input  logic                               instr_valid_i,
    input  logic [31:0]                        instr_i,
    output logic                               ready_o,
    output logic                               wb_valid_o,
    output logic [rv_exec_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [rv_exec_pkg::XLEN-1:0]       wb_data_o,
    output logic                               br_valid_o,
    output logic                               br_taken_o,
    output logic                               st_valid_o,
    output logic [rv_exec_pkg::XLEN-1:0]       st_addr_o,
    output logic [rv_exec_pkg::XLEN-1:0]       st_data_o,
    output logic                               illegal_o
);

    logic [31:0]                  instr_q;
    rv_exec_pkg::decode_t         dec;
    rv_exec_pkg::alu_ctrl_e       alu_ctrl;
    logic                         alu_illegal;
    logic [rv_exec_pkg::XLEN-1:0] rs1_data;
    logic [rv_exec_pkg::XLEN-1:0] rs2_data;
    logic                         cnt_load;
    logic                         cnt_step;
    logic                         cnt_last;
    logic                         rf_we;
    logic [rv_exec_pkg::XLEN-1:0] rf_wd;

    alu_if alu_bus ();

    main_decoder u_main_decoder (
        .instr_i (instr_q),
        .dec_o   (dec)
    );

    alu_decoder u_alu_decoder (
        .alu_op_i      (dec.alu_op),
        .funct3_i      (instr_q[14:12]),
        .funct7_i      (instr_q[31:25]),
        .alu_control_o (alu_ctrl),
        .illegal_o     (alu_illegal)
    );

    alu u_alu (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .bus      (alu_bus)
    );

    shift_counter u_shift_counter (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .load_i   (cnt_load),
        .amount_i (alu_bus.operand_b[rv_exec_pkg::SHAMT_W-1:0]),  // shamt from rs2 or imm
        .step_i   (cnt_step),
        .last_o   (cnt_last)
    );

    register_file u_register_file (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .rs1_addr_i (instr_q[19:15]),
        .rs2_addr_i (instr_q[24:20]),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rf_we),
        .rd_addr_i  (wb_rd_o),
        .rd_data_i  (rf_wd)
    );

    exec_fsm u_exec_fsm (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .ready_o       (ready_o),
        .dec_i         (dec),
        .alu_illegal_i (alu_illegal),
        .alu_ctrl_i    (alu_ctrl),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .bus           (alu_bus),
        .cnt_load_o    (cnt_load),
        .cnt_step_o    (cnt_step),
        .cnt_last_i    (cnt_last),
        .rf_we_o       (rf_we),
        .rf_wd_o       (rf_wd),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .br_valid_o    (br_valid_o),
        .br_taken_o    (br_taken_o),
        .st_valid_o    (st_valid_o),
        .st_addr_o     (st_addr_o),
        .st_data_o     (st_data_o),
        .illegal_o     (illegal_o),
        .instr_q_o     (instr_q)
    );

endmodule

/* shift_counter.sv */
`timescale 1ns/10ps

module shift_counter (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  logic                            load_i,
    input  logic [rv_exec_pkg::SHAMT_W-1:0] amount_i,
    input  logic                            step_i,
    output logic                            last_o
);

    logic [rv_exec_pkg::SHAMT_W-1:0] count_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= amount_i;
        end else if (step_i && (count_q != '0)) begin
            count_q <= count_q - 1'b1;
        end
    end

    // Step that takes the count from 1 to 0
    assign last_o = step_i && (count_q == rv_exec_pkg::SHAMT_W'(1));

endmodule

/* tb_rv_exec.sv */
`timescale 1ns/10ps

module tb_rv_exec;

    localparam int N_READ    = 16;
    localparam int N_ALU     = 200;
    localparam int N_SHIFT   = 32;
    localparam int N_BRANCH  = 40;
    localparam int N_STORE   = 30;
    localparam int N_ILLEGAL = 18;  // Nine bad encodings, each followed by a read
    localparam int N_TOTAL   = N_READ + N_ALU + N_SHIFT + N_BRANCH + N_STORE + N_ILLEGAL;
    localparam int WD_CYCLES = N_TOTAL * 40 + 10;

    logic        clk_i = 1'b0;
    logic        arst_n_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic        ready_o;
    logic        wb_valid_o;
    logic [4:0]  wb_rd_o;
    logic [31:0] wb_data_o;
    logic        br_valid_o;
    logic        br_taken_o;
    logic        st_valid_o;
    logic [31:0] st_addr_o;
    logic [31:0] st_data_o;
    logic        illegal_o;

    logic [31:0] model_regs [32];
    int          error_count  = 0;
    int          check_count  = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          errors_at_start = 0;

    rv_exec_top DUT (.*);

    always #5 clk_i = ~clk_i;

    initial begin
        repeat (WD_CYCLES) @(posedge clk_i);
        $display("Timeout: the run did not finish within %0d cycles", WD_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("Test %0d (%s): passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d (%s): FAILED, %0d errors", tests_run, name,
                     error_count - errors_at_start);
        end
        errors_at_start = error_count;
    endtask

    function automatic logic [31:0] sign_extend12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [4:0] random_reg();
        return 5'($urandom_range(0, 31));
    endfunction

    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // Reference ALU where alt selects SUB and SRA
    function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Strobe one word in, count cycles from the accept edge to the outcome pulse
    task automatic issue_instr(input logic [31:0] instr, output int lat);
        @(negedge clk_i);
        while (!ready_o) @(negedge clk_i);
        @(posedge clk_i);
        instr_valid_i <= 1'b1;
        instr_i       <= instr;
        @(posedge clk_i);  // Accept edge
        instr_valid_i <= 1'b0;
        lat = 0;
        do begin
            @(negedge clk_i);
            lat++;
        end while (!(wb_valid_o || br_valid_o || st_valid_o || illegal_o));
    endtask

    task automatic run_and_check(input logic [31:0] instr);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] exp_val;
        logic [3:0]  exp_pulse;  // wb, br, st, illegal
        int          exp_lat;
        int          lat;
        f3        = instr[14:12];
        f7        = instr[31:25];
        rd        = instr[11:7];
        a         = model_regs[instr[19:15]];
        b         = model_regs[instr[24:20]];
        exp_val   = '0;
        exp_lat   = 3;
        exp_pulse = 4'b0001;
        case (instr[6:0])
            7'b0110011: begin
                if ((f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)))) begin
                    exp_pulse = 4'b1000;
                    exp_val   = model_alu(f3, f7[5], a, b);
                    if ((f3 == 3'd1) || (f3 == 3'd5)) exp_lat = 3 + int'(b[4:0]);
                end
            end
            7'b0010011: begin
                b = sign_extend12(instr[31:20]);
                if (!(((f3 == 3'd1) && (f7 != 7'h00)) ||
                      ((f3 == 3'd5) && (f7 != 7'h00) && (f7 != 7'h20)))) begin
                    exp_pulse = 4'b1000;
                    exp_val   = model_alu(f3, (f3 == 3'd5) && f7[5], a, b);
                    if ((f3 == 3'd1) || (f3 == 3'd5)) exp_lat = 3 + int'(b[4:0]);
                end
            end
            7'b1100011: begin
                if ((f3 == 3'd0) || (f3 == 3'd1)) begin
                    exp_pulse = 4'b0100;
                    exp_val   = {31'b0, (a == b) ^ f3[0]};  // BNE inverts
                end
            end
            7'b0100011: begin
                if (f3 == 3'd2) begin
                    exp_pulse = 4'b0010;
                    exp_val   = a + sign_extend12({f7, rd});
                end
            end
            default: begin
                exp_pulse = 4'b0001;
            end
        endcase
        issue_instr(instr, lat);
        check_value("outcome pulses", 32'({wb_valid_o, br_valid_o, st_valid_o, illegal_o}),
                    32'(exp_pulse));
        check_value("latency", lat, exp_lat);
        if (exp_pulse == 4'b1000) begin
            if (rd != 5'd0) model_regs[rd] = exp_val;
            else exp_val = '0;
            check_value("wb_rd_o", 32'(wb_rd_o), 32'(rd));
            check_value("wb_data_o", wb_data_o, exp_val);
        end else if (exp_pulse == 4'b0100) begin
            check_value("br_taken_o", 32'(br_taken_o), exp_val);
        end else if (exp_pulse == 4'b0010) begin
            check_value("st_addr_o", st_addr_o, exp_val);
            check_value("st_data_o", st_data_o, b);
        end
    endtask

    initial begin
        logic [31:0] instr;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [4:0]  rd;
        void'($urandom(30));
        arst_n_i      = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (2) @(posedge clk_i);
        arst_n_i <= 1'b1;

        @(negedge clk_i);
        check_value("ready_o after reset", 32'(ready_o), 32'd1);
        check_value("pulses after reset",
                    32'({wb_valid_o, br_valid_o, st_valid_o, illegal_o}), 32'd0);
        for (int i = 0; i < N_READ; i++) begin
            run_and_check(rtype_word(7'h00, 5'(2 * i + 1), 5'(2 * i), 3'd0, 5'd1));
        end
        report_test("reset and register read");

        for (int i = 0; i < N_ALU; i++) begin
            f3 = 3'($urandom_range(0, 7));
            rd = (i % 25 == 0) ? 5'd0 : random_reg();  // Some writes to x0
            if ($urandom_range(0, 1) == 0) begin
                f7 = (((f3 == 3'd0) || (f3 == 3'd5)) && ($urandom_range(0, 1) == 1)) ? 7'h20
                                                                                    : 7'h00;
                instr = rtype_word(f7, random_reg(), random_reg(), f3, rd);
            end else begin
                imm = 12'($urandom());
                if (f3 == 3'd1) imm[11:5] = 7'h00;
                if (f3 == 3'd5) imm[11:5] = imm[10] ? 7'h20 : 7'h00;
                instr = itype_word(imm, random_reg(), f3, rd);
            end
            run_and_check(instr);
        end
        report_test("random R-type and I-type");

        for (int amt = 0; amt < N_SHIFT; amt++) begin
            f3    = ($urandom_range(0, 1) == 1) ? 3'd1 : 3'd5;
            f7    = ((f3 == 3'd5) && ($urandom_range(0, 1) == 1)) ? 7'h20 : 7'h00;
            instr = itype_word({f7, 5'(amt)}, random_reg(), f3, random_reg());
            run_and_check(instr);
        end
        report_test("shifts by 0 to 31");

        for (int i = 0; i < N_BRANCH; i++) begin
            instr        = $urandom();
            instr[6:0]   = 7'b1100011;
            instr[14:13] = 2'b00;  // BEQ or BNE
            if (i % 2 == 0) instr[24:20] = instr[19:15];  // Equal operands
            run_and_check(instr);
        end
        report_test("BEQ and BNE");

        for (int i = 0; i < N_STORE; i++) begin
            instr        = $urandom();
            instr[6:0]   = 7'b0100011;
            instr[14:12] = 3'd2;
            run_and_check(instr);
        end
        report_test("SW");

        for (int i = 0; i < N_ILLEGAL / 2; i++) begin
            rd = 5'($urandom_range(1, 31));
            case (i % 3)
                0: begin
                    f7 = 7'($urandom_range(1, 127));
                    if (f7 == 7'h20) f7 = 7'h21;
                    instr = rtype_word(f7, random_reg(), random_reg(),
                                       3'($urandom_range(0, 7)), rd);
                end
                1: begin
                    f3    = (i % 2 == 0) ? 3'd1 : 3'd5;
                    f7    = 7'h40 | 7'($urandom_range(0, 31));  // Neither 00 nor 20
                    instr = itype_word({f7, random_reg()}, random_reg(), f3, rd);
                end
                default: begin
                    instr        = $urandom();
                    instr[6:0]   = 7'b0000011;  // Unsupported load opcode
                    instr[14:12] = 3'd0;
                    instr[11:7]  = rd;
                end
            endcase
            run_and_check(instr);
            // SW from x0 base shows the target register on st_data_o
            run_and_check({7'h00, rd, 5'd0, 3'd2, 5'd0, 7'b0100011});
        end
        report_test("illegal encodings");

        $display("Tests run %0d, failed %0d; checks %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, check_count, error_count, DUT.u_chk.fail_count);
        if ((error_count == 0) && (tests_failed == 0) && (DUT.u_chk.fail_count == 0)) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
